/* source/backup_params.svh */
// Image geometry and format header for the backup RAM save path
// Image size is fixed at BK_SECTORS x BK_SECTOR_WORDS 16-bit words
`ifndef BACKUP_PARAMS_SVH
`define BACKUP_PARAMS_SVH

////////////////////////////////////////
// Image geometry
////////////////////////////////////////

`define BK_SECTORS        4    // Sectors per save image
`define BK_SECTOR_WORDS   256  // 16-bit words per sector

////////////////////////////////////////
// Format header
////////////////////////////////////////

// Header words written by a format, low byte first on the console side
`define BK_DEFAULT_WORDS  4
`define BK_DEFAULT_0      16'h5548  // "HU"
`define BK_DEFAULT_1      16'h4D42  // "BM"
`define BK_DEFAULT_2      16'h8800
`define BK_DEFAULT_3      16'h8010

`endif

/* source/backup_pkg.sv */
// Shared types of the backup RAM save path
// Sector index width follows BK_SECTORS from the params header
`include "backup_params.svh"

package backup_pkg;

	// Console side
	typedef logic [7:0]  byte_t;
	typedef logic [10:0] byte_addr_t;  // 2 KB of bytes

	// SD host side
	typedef logic [15:0] word_t;
	typedef logic [$clog2(`BK_SECTOR_WORDS)-1:0] buff_addr_t;
	typedef logic [$clog2(`BK_SECTORS)-1:0]      sector_t;

	////////////////////////////////////////
	// Transfer sequencer
	////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,          // Waiting for a request
		REQUEST,       // sd_rd or sd_wr raised, waiting for sd_ack
		WAIT_ACK_END   // Host moving the sector
	} seq_state_t;

endpackage

/* source/transfer_sequencer.sv */
// Steps a load or save through all sectors of the image, one request per sector
// Requests are edge triggered and ignored while busy or with no image mounted
module transfer_sequencer import backup_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave_req,
	input  logic download_done,
	input  logic mounted,
	input  logic sd_ack,
	input  logic last,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy,
	output logic loading,
	output logic clear,
	output logic advance
);

	seq_state_t state;

	logic load_d, save_d, autosave_d, done_d, ack_d;
	logic start_load, start_save, start, finish;
	logic ack_rise, ack_fall;

	assign ack_rise   = sd_ack & ~ack_d;
	assign ack_fall   = ~sd_ack & ack_d;
	assign start_load = (load_req & ~load_d) | (download_done & ~done_d);
	assign start_save = (save_req & ~save_d) | (autosave_req & ~autosave_d);
	assign start      = (state == IDLE) & mounted & (start_load | start_save);
	assign finish     = (state == WAIT_ACK_END) & ack_fall & last;

	// Counter goes back to sector 0 at both ends of a transfer
	assign clear   = start | finish;
	assign advance = (state == WAIT_ACK_END) & ack_fall & ~last;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= IDLE;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			busy       <= 1'b0;
			loading    <= 1'b0;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			autosave_d <= 1'b0;
			done_d     <= 1'b0;
			ack_d      <= 1'b0;
		end else begin
			load_d     <= load_req;
			save_d     <= save_req;
			autosave_d <= autosave_req;
			done_d     <= download_done;
			ack_d      <= sd_ack;

			case (state)
				IDLE: begin
					if (start) begin
						state   <= REQUEST;
						busy    <= 1'b1;
						loading <= start_load;   // Load wins over save
						sd_rd   <= start_load;
						sd_wr   <= ~start_load;
					end
				end
				REQUEST: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= WAIT_ACK_END;
					end
				end
				WAIT_ACK_END: begin
					if (finish) begin
						state   <= IDLE;
						busy    <= 1'b0;
						loading <= 1'b0;
					end else if (ack_fall) begin
						state <= REQUEST;   // Next sector
						sd_rd <= loading;
						sd_wr <= ~loading;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* source/sector_counter.sv */
// Sector index of the transfer in progress, driven onto sd_lba
`include "backup_params.svh"

module sector_counter import backup_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    clear,
	input  logic    advance,
	output sector_t sd_lba,
	output logic    last
);

	localparam sector_t LAST_SECTOR = sector_t'(`BK_SECTORS - 1);

	assign last = (sd_lba == LAST_SECTOR);

	always_ff @(posedge clk_sys) begin
		if (reset || clear) begin
			sd_lba <= '0;
		end else if (advance) begin
			// Wrap at the image end
			if (last) begin
				sd_lba <= '0;
			end else begin
				sd_lba <= sd_lba + 1'b1;
			end
		end
	end

endmodule

/* source/backup_ram.sv */
// 2 KB backup RAM, bytes on port A for the console, words on port B for the host
// Port A wins when both ports write the same word in one cycle
`include "backup_params.svh"

module backup_ram import backup_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  byte_addr_t bram_addr,
	input  byte_t      bram_data,
	input  logic       bram_wr,
	output byte_t      bram_q,
	input  sector_t    sector,
	input  buff_addr_t sd_buff_addr,
	input  word_t      sd_buff_dout,
	input  logic       sd_buff_wr,
	input  logic       sd_ack,
	input  logic       loading,
	input  logic       format_req,
	output word_t      sd_buff_din
);

	localparam int WORDS       = `BK_SECTORS * `BK_SECTOR_WORDS;
	localparam int WORD_ADDR_W = $clog2(WORDS);
	localparam word_t DEFAULTS [`BK_DEFAULT_WORDS] =
		'{`BK_DEFAULT_0, `BK_DEFAULT_1, `BK_DEFAULT_2, `BK_DEFAULT_3};

	byte_t mem_lo [WORDS];   // Even console bytes
	byte_t mem_hi [WORDS];   // Odd console bytes

	logic [WORD_ADDR_W-1:0] a_addr, b_addr;
	logic [2:0] fmt_idx;
	logic       fmt_active, format_d, b_we, a_sel;
	byte_t      a_lo, a_hi;
	word_t      b_data;

	assign a_addr     = bram_addr[$bits(byte_addr_t)-1:1];
	assign fmt_active = (fmt_idx < 3'(`BK_DEFAULT_WORDS));

	// Format fill takes over port B for four cycles
	assign b_addr = fmt_active ? WORD_ADDR_W'(fmt_idx) : {sector, sd_buff_addr};
	assign b_data = fmt_active ? DEFAULTS[fmt_idx[1:0]] : sd_buff_dout;
	assign b_we   = fmt_active | (sd_buff_wr & sd_ack & loading);

	assign bram_q = a_sel ? a_hi : a_lo;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fmt_idx  <= 3'(`BK_DEFAULT_WORDS);   // Idle
			format_d <= 1'b0;
		end else begin
			format_d <= format_req;
			if (format_req && !format_d) fmt_idx <= '0;
			else if (fmt_active) fmt_idx <= fmt_idx + 1'b1;
		end
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (b_we) begin
			mem_lo[b_addr] <= b_data[7:0];
			mem_hi[b_addr] <= b_data[15:8];
		end
		if (bram_wr) begin
			if (bram_addr[0]) mem_hi[a_addr] <= bram_data;
			else mem_lo[a_addr] <= bram_data;
		end
		a_lo        <= mem_lo[a_addr];
		a_hi        <= mem_hi[a_addr];
		a_sel       <= bram_addr[0];                    // Byte lane for next cycle
		sd_buff_din <= {mem_hi[b_addr], mem_lo[b_addr]};
	end

endmodule

/* source/save_tracker.sv */
// Save image mount state, pending changes flag and autosave trigger
// A writable image must be mounted during each cartridge download
module save_tracker import backup_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic downloading,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic bram_wr,
	input  logic osd_open,
	input  logic autosave_en,
	input  logic busy,
	output logic mounted,
	output logic download_done,
	output logic autosave_req,
	output logic pending
);

	logic downloading_d;

	assign download_done = downloading_d & ~downloading;
	assign autosave_req  = pending & osd_open & autosave_en;   // Save when the menu opens

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			downloading_d <= 1'b0;
			mounted       <= 1'b0;
			pending       <= 1'b0;
		end else begin
			downloading_d <= downloading;

			if (downloading && !downloading_d) mounted <= 1'b0;     // New cartridge
			if (downloading && img_mounted && !img_readonly) mounted <= 1'b1;

			if (mounted && bram_wr && !osd_open) pending <= 1'b1;
			else if (busy) pending <= 1'b0;
		end
	end

endmodule

/* source/backup_ram_manager.sv */
// Backup RAM with SD save and load; sd_lba is the sector within the image only
// The host adds its own base and pads sd_lba to its width
module backup_ram_manager import backup_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	// Console port
	input  byte_addr_t bram_addr,
	input  byte_t      bram_data,
	input  logic       bram_wr,
	output byte_t      bram_q,
	// SD host port
	output logic       sd_rd,
	output logic       sd_wr,
	output sector_t    sd_lba,
	input  logic       sd_ack,
	input  buff_addr_t sd_buff_addr,
	input  word_t      sd_buff_dout,
	input  logic       sd_buff_wr,
	output word_t      sd_buff_din,
	// Control and status
	input  logic       load_req,
	input  logic       save_req,
	input  logic       autosave_en,
	input  logic       osd_open,
	input  logic       downloading,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  logic       format_req,
	output logic       busy,
	output logic       loading,
	output logic       pending
);

	logic mounted, download_done, autosave_req;
	logic clear, advance, last;

	save_tracker save_tracker_inst (
		.clk_sys, .reset, .downloading, .img_mounted, .img_readonly,
		.bram_wr, .osd_open, .autosave_en, .busy,
		.mounted, .download_done, .autosave_req, .pending
	);

	transfer_sequencer transfer_sequencer_inst (
		.clk_sys, .reset, .load_req, .save_req, .autosave_req, .download_done,
		.mounted, .sd_ack, .last,
		.sd_rd, .sd_wr, .busy, .loading, .clear, .advance
	);

	sector_counter sector_counter_inst (
		.clk_sys, .reset, .clear, .advance, .sd_lba, .last
	);

	backup_ram backup_ram_inst (
		.clk_sys, .reset, .bram_addr, .bram_data, .bram_wr, .bram_q,
		.sector(sd_lba),
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_ack, .loading,
		.format_req, .sd_buff_din
	);

endmodule

/* bench/backup_checker.sv */
// Watches the backup RAM manager ports, keeps a model of the RAM and counts errors
// The model assumes console and host never write the same word in one cycle
`include "backup_params.svh"

module backup_checker import backup_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  byte_addr_t  bram_addr,
	input  byte_t       bram_data,
	input  logic        bram_wr,
	input  byte_t       bram_q,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  sector_t     sd_lba,
	input  logic        sd_ack,
	input  buff_addr_t  sd_buff_addr,
	input  word_t       sd_buff_dout,
	input  logic        sd_buff_wr,
	input  word_t       sd_buff_din,
	input  logic        format_req,
	input  logic        busy,
	input  logic        loading,
	input  logic        pending,
	input  logic [1:0]  chk_kind,
	input  logic [15:0] chk_value,
	input  logic        want_load,
	output int          mismatches,
	output int          violations
);
	timeunit 1ns;
	timeprecision 1ps;

	byte_t      model [2 * `BK_SECTORS * `BK_SECTOR_WORDS];
	sector_t    exp_sector;
	int         sectors_done, transfers, cap_addr;
	logic       ack_d, busy_d, reset_d, format_d, read_d, cap_valid, saving;
	byte_addr_t read_addr;
	byte_t      read_exp;

	function automatic int word_index(sector_t s, buff_addr_t w);
		return int'(s) * `BK_SECTOR_WORDS + int'(w);
	endfunction

	task automatic put_word(input int a, input word_t w);
		model[2 * a]     = w[7:0];   // Low byte at the even console address
		model[2 * a + 1] = w[15:8];
	endtask

	task automatic violation(input string what);
		violations++;
		$display("Protocol error at %0t: %s", $time, what);
	endtask

	task automatic mismatch(input string what);
		mismatches++;
		$display("Mismatch at %0t: %s", $time, what);
	endtask

	always @(posedge clk_sys) begin
		reset_d   <= reset;
		ack_d     <= sd_ack;
		busy_d    <= busy;
		format_d  <= format_req;
		read_d    <= (chk_kind == 2'd1);
		read_addr <= bram_addr;
		read_exp  <= chk_value[7:0];

		if (reset_d === 1'b1 && reset === 1'b0 &&
				({sd_rd, sd_wr, busy, loading, pending} !== 5'b0 || sd_lba !== '0))
			violation("outputs not idle after reset");
		if (sd_rd && sd_wr) violation("sd_rd and sd_wr high together");
		if ((sd_rd || sd_wr) && sd_ack && ack_d) violation("request still high during sd_ack");
		if (loading && !busy) violation("loading high while not busy");
		if (sd_rd && !loading) violation("sd_rd raised without loading");
		if (sd_wr && loading) violation("sd_wr raised during a load");

		////////////////////////////////////////
		// RAM model
		////////////////////////////////////////
		if (bram_wr) model[bram_addr] = bram_data;
		if (format_req && !format_d) begin
			put_word(0, `BK_DEFAULT_0);
			put_word(1, `BK_DEFAULT_1);
			put_word(2, `BK_DEFAULT_2);
			put_word(3, `BK_DEFAULT_3);
		end

		if (reset) begin
			sectors_done = 0;
			transfers    = 0;
			exp_sector   = '0;
			cap_valid   <= 1'b0;
		end else begin
			if (sd_ack && !ack_d) begin
				saving = sd_wr;
				if (sd_lba != exp_sector)
					violation($sformatf("sector %0d served, expected %0d", sd_lba, exp_sector));
				if (sd_rd !== want_load)
					mismatch($sformatf("sector %0d requested with sd_rd %b, expected %b",
						sd_lba, sd_rd, want_load));
			end
			if (sd_ack && sd_buff_wr) put_word(word_index(exp_sector, sd_buff_addr), sd_buff_dout);
			if (!sd_ack && ack_d) begin
				exp_sector++;
				sectors_done++;
			end
			if (!busy && busy_d) begin
				if (sectors_done != `BK_SECTORS)
					violation($sformatf("transfer ended after %0d sectors", sectors_done));
				transfers++;
				sectors_done = 0;
				exp_sector   = '0;
			end

			// Saved word appears one cycle after its address
			if (cap_valid && sd_buff_din !== {model[2 * cap_addr + 1], model[2 * cap_addr]})
				mismatch($sformatf("saved word %0d is %h, expected %h", cap_addr, sd_buff_din,
					{model[2 * cap_addr + 1], model[2 * cap_addr]}));
			cap_valid <= sd_ack && saving;
			cap_addr  <= word_index(exp_sector, sd_buff_addr);
		end

		if (read_d && bram_q !== read_exp)
			mismatch($sformatf("console byte %h read %h, expected %h", read_addr, bram_q, read_exp));
		if (chk_kind == 2'd2 && transfers != int'(chk_value))
			mismatch($sformatf("%0d transfers done, expected %0d", transfers, chk_value));
		if (chk_kind == 2'd3 && pending !== chk_value[0])
			mismatch($sformatf("pending is %b, expected %b", pending, chk_value[0]));
	end

endmodule

/* bench/backup_tb.sv */
// Testbench for the backup RAM manager, to be run from the project root
// Operations come from bench/backup_vectors.txt and are compared in backup_checker
`include "backup_params.svh"

module backup_tb import backup_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic        clk_sys = 1'b0;
	logic        reset = 1'b1;
	byte_addr_t  bram_addr = '0;
	byte_t       bram_data = '0;
	logic        bram_wr = 1'b0;
	byte_t       bram_q;
	logic        sd_rd, sd_wr;
	sector_t     sd_lba;
	logic        sd_ack = 1'b0;
	buff_addr_t  sd_buff_addr = '0;
	word_t       sd_buff_dout = '0;
	logic        sd_buff_wr = 1'b0;
	word_t       sd_buff_din;
	logic        load_req = 1'b0;
	logic        save_req = 1'b0;
	logic        autosave_en = 1'b0;
	logic        osd_open = 1'b0;
	logic        downloading = 1'b0;
	logic        img_mounted = 1'b0;
	logic        img_readonly = 1'b0;
	logic        format_req = 1'b0;
	logic        busy, loading, pending;
	logic [1:0]  chk_kind = 2'd0;     // 1 read, 2 transfers, 3 pending
	logic [15:0] chk_value = '0;
	logic        want_load = 1'b0;    // High when the current operation should load
	int          mismatches, violations;
	int          bad_vectors = 0;
	int          n_vectors = 0;
	integer      seed = 12;
	word_t       host_key = '0;
	logic [15:0] op_q [$];
	logic [15:0] addr_q [$];
	logic [15:0] data_q [$];

	always #10 clk_sys = ~clk_sys;

	backup_ram_manager backup_ram_manager_inst (.*);
	backup_checker backup_checker_inst (.*);

	////////////////////////////////////////
	// SD host model
	////////////////////////////////////////

	// Host data pattern of A0 plus sector in the high byte and word index in the low byte
	function automatic word_t host_word(sector_t sec, int w);
		return {8'hA0 | 8'(sec), 8'(w)} ^ host_key;
	endfunction

	task automatic serve_sector();
		logic    is_load;
		sector_t sec;
		int      w;
		int      gap;
		is_load = sd_rd;
		sec     = sd_lba;
		sd_ack  = 1'b1;
		for (w = 0; w < `BK_SECTOR_WORDS; w++) begin
			sd_buff_addr = buff_addr_t'(w);
			sd_buff_dout = host_word(sec, w);
			sd_buff_wr   = is_load;
			@(negedge clk_sys);
		end
		sd_buff_wr = 1'b0;
		gap = $random(seed) & 15;   // Stretch sd_ack
		repeat (gap) @(negedge clk_sys);
		sd_ack = 1'b0;
	endtask

	always begin
		@(negedge clk_sys);
		if (!reset && (sd_rd || sd_wr)) serve_sector();
	end

	////////////////////////////////////////
	// Vector operations
	////////////////////////////////////////

	task automatic wait_idle();
		repeat (2) @(negedge clk_sys);   // busy rises one cycle after the edge
		while (busy) @(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic post_check(input logic [1:0] kind, input logic [15:0] value);
		chk_kind  = kind;
		chk_value = value;
		@(negedge clk_sys);
		chk_kind = 2'd0;
	endtask

	task automatic apply_vector(input logic [15:0] op, input logic [15:0] addr,
			input logic [15:0] data);
		case (op)
			16'h1: begin
				bram_addr = byte_addr_t'(addr);
				bram_data = byte_t'(data);
				bram_wr   = 1'b1;
				@(negedge clk_sys);
				bram_wr = 1'b0;
			end
			16'h2: begin
				bram_addr = byte_addr_t'(addr);
				post_check(2'd1, data);
			end
			16'h3: begin
				format_req = 1'b1;
				@(negedge clk_sys);
				format_req = 1'b0;
				repeat (`BK_DEFAULT_WORDS + 1) @(negedge clk_sys);
			end
			16'h4: begin
				want_load   = 1'b1;
				downloading = 1'b1;
				@(negedge clk_sys);
				img_readonly = data[0];
				img_mounted  = 1'b1;
				@(negedge clk_sys);
				img_mounted = 1'b0;
				@(negedge clk_sys);
				downloading = 1'b0;   // End of download starts the auto load if mounted
				wait_idle();
			end
			16'h5: begin
				want_load = 1'b1;
				load_req  = 1'b1;
				wait_idle();
				load_req = 1'b0;
			end
			16'h6: begin
				want_load = 1'b0;
				save_req  = 1'b1;
				wait_idle();
				save_req = 1'b0;
			end
			16'h7: begin
				want_load   = 1'b0;
				autosave_en = data[0];
				osd_open    = 1'b1;
				wait_idle();
				osd_open = 1'b0;
			end
			16'h8: host_key = data;
			16'h9: post_check(2'd2, data);
			16'hA: post_check(2'd3, data);
			default: begin
				$display("Unknown operation %h in the vector file", op);
				bad_vectors++;
			end
		endcase
	endtask

	task automatic end_run(input bit aborted);
		$display("Errors: %0d mismatches, %0d protocol, %0d other",
			mismatches, violations, bad_vectors + int'(aborted));
		if (aborted || bad_vectors != 0 || mismatches != 0 || violations != 0) begin
			$display("TEST FAILED");
		end else begin
			$display("TEST PASSED");
		end
		$finish;
	endtask

	initial begin : main
		int               fd;
		int               code;
		logic [15:0]      op, addr, data;
		logic [8*128-1:0] rest;
		fd = $fopen("bench/backup_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/backup_vectors.txt");
			end_run(1'b1);
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%h %h %h\n", op, addr, data);
				if (code == 3) begin
					op_q.push_back(op);
					addr_q.push_back(addr);
					data_q.push_back(data);
				end else if (code >= 0) begin
					code = $fgets(rest, fd);   // Comment line
				end
			end
			$fclose(fd);
			n_vectors = op_q.size();
			if (n_vectors == 0) bad_vectors++;
			repeat (10) @(posedge clk_sys);
			@(negedge clk_sys);
			reset = 1'b0;
			foreach (op_q[i]) apply_vector(op_q[i], addr_q[i], data_q[i]);
			repeat (5) @(negedge clk_sys);
			end_run(1'b0);
		end
	end

	// Watchdog allows 2000 cycles per vector
	initial begin : watchdog
		wait (n_vectors > 0);
		repeat (n_vectors * 2000) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", n_vectors * 2000);
		end_run(1'b1);
	end

endmodule

/* backup_ram_manager.f */
+incdir+source
source/backup_pkg.sv
source/transfer_sequencer.sv
source/sector_counter.sv
source/backup_ram.sv
source/save_tracker.sv
source/backup_ram_manager.sv
bench/backup_checker.sv
bench/backup_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := backup_tb
FILELIST  := backup_ram_manager.f
VFLAGS    := --timing --timescale 1ns/1ps --top-module $(TOP)
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/backup_vectors.txt */
# op addr data, all hex. op: 1 console write, 2 console read expect, 3 format, 4 mount (data = readonly)
# 5 load, 6 save, 7 open OSD (data = autosave_en), 8 host data key, 9 expect transfers, A expect pending
5 000 0000
6 000 0000
4 000 0001
9 000 0000
8 000 1234
4 000 0000
9 000 0001
2 000 0034
2 001 00B2
2 202 0035
2 203 00B3
2 5A5 00B0
2 7FE 00CB
2 7FF 00B1
1 010 005A
A 000 0001
1 7FF 00C3
6 000 0000
9 000 0002
A 000 0000
3 000 0000
2 000 0048
6 000 0000
9 000 0003
1 123 0077
7 000 0000
9 000 0003
A 000 0001
7 000 0001
9 000 0004
A 000 0000
